// File: Makefile
# Verilator build and run for the SoC testbench
VERILATOR  ?= verilator
TOP        ?= tb_soc_top
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: list.f
verilog/soc_pkg.sv
verilog/soc_bus_if.sv
verilog/soc_reset_gen.sv
verilog/soc_xbar.sv
verilog/soc_clint.sv
verilog/soc_plic.sv
verilog/soc_scratch_mem.sv
verilog/soc_top.sv
verif/soc_xbar_properties.sv
verif/tb_clk_gen.sv
verif/tb_soc_top.sv

// File: verif/soc_xbar_properties.sv
/*
 * soc_xbar_properties
 * Master-side handshake checks of the interconnect, bound to soc_xbar.
 */
`timescale 1ns/1ps

module soc_xbar_properties (
  input logic clk_i,
  input logic rst_i,
  input logic dbg_req_i,
  input logic dbg_gnt_i,
  input logic dbg_rvalid_i,
  input logic core_req_i,
  input logic core_gnt_i,
  input logic core_rvalid_i
);

  // number of failed assertions so far
  int unsigned fail_count = 0;

  a_dbg_gnt_req: assert property (@(posedge clk_i) disable iff (rst_i)
    dbg_gnt_i |-> dbg_req_i)
    else begin
      fail_count++;
      $error("debug gnt without debug req");
    end

  a_core_gnt_req: assert property (@(posedge clk_i) disable iff (rst_i)
    core_gnt_i |-> core_req_i)
    else begin
      fail_count++;
      $error("core gnt without core req");
    end

  // one grant per cycle
  a_one_grant: assert property (@(posedge clk_i) disable iff (rst_i)
    !(dbg_gnt_i && core_gnt_i))
    else begin
      fail_count++;
      $error("debug and core granted in the same cycle");
    end

  a_dbg_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
    dbg_gnt_i |=> dbg_rvalid_i)
    else begin
      fail_count++;
      $error("debug rvalid missing one cycle after gnt");
    end

  a_core_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
    core_gnt_i |=> core_rvalid_i)
    else begin
      fail_count++;
      $error("core rvalid missing one cycle after gnt");
    end

endmodule

bind soc_xbar soc_xbar_properties i_xbar_props (
  .clk_i         ( clk_i       ),
  .rst_i         ( rst_i       ),
  .dbg_req_i     ( dbg.req     ),
  .dbg_gnt_i     ( dbg.gnt     ),
  .dbg_rvalid_i  ( dbg.rvalid  ),
  .core_req_i    ( core.req    ),
  .core_gnt_i    ( core.gnt    ),
  .core_rvalid_i ( core.rvalid )
);

// File: verif/tb_clk_gen.sv
/*
 * tb_clk_gen
 * Testbench clock of 10 ns and a synchronous reset held for 8 cycles.
 */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (8) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

// File: verif/tb_soc_top.sv
/*
 * tb_soc_top
 * Directed tests of the SoC memory map: scratch memory, arbitration,
 * CLINT timer and software interrupt, PLIC and the non-debug reset.
 */
`timescale 1ns/1ps

module tb_soc_top;
  import soc_pkg::*;

  logic clk;
  logic rst;
  logic ndmreset;
  logic core_req;
  logic core_gnt;
  logic core_we;
  logic [AddrWidth-1:0] core_addr;
  logic [BeWidth-1:0] core_be;
  logic [DataWidth-1:0] core_wdata;
  logic core_rvalid;
  logic [DataWidth-1:0] core_rdata;
  logic dbg_req;
  logic dbg_gnt;
  logic dbg_we;
  logic [AddrWidth-1:0] dbg_addr;
  logic [BeWidth-1:0] dbg_be;
  logic [DataWidth-1:0] dbg_wdata;
  logic dbg_rvalid;
  logic [DataWidth-1:0] dbg_rdata;
  logic [NumSources-1:0] irq_sources;
  logic timer_irq;
  logic ipi;
  logic [NumTargets-1:0] eip;

  // word left in memory by the first test, read again after ndmreset
  logic [DataWidth-1:0] kept_word;

  tb_clk_gen i_clk_gen (
    .clk_o ( clk ),
    .rst_o ( rst )
  );

  soc_top DUT (
    .clk_i         ( clk         ),
    .rst_i         ( rst         ),
    .ndmreset_i    ( ndmreset    ),
    .core_req_i    ( core_req    ),
    .core_gnt_o    ( core_gnt    ),
    .core_we_i     ( core_we     ),
    .core_addr_i   ( core_addr   ),
    .core_be_i     ( core_be     ),
    .core_wdata_i  ( core_wdata  ),
    .core_rvalid_o ( core_rvalid ),
    .core_rdata_o  ( core_rdata  ),
    .dbg_req_i     ( dbg_req     ),
    .dbg_gnt_o     ( dbg_gnt     ),
    .dbg_we_i      ( dbg_we      ),
    .dbg_addr_i    ( dbg_addr    ),
    .dbg_be_i      ( dbg_be      ),
    .dbg_wdata_i   ( dbg_wdata   ),
    .dbg_rvalid_o  ( dbg_rvalid  ),
    .dbg_rdata_o   ( dbg_rdata   ),
    .irq_sources_i ( irq_sources ),
    .timer_irq_o   ( timer_irq   ),
    .ipi_o         ( ipi         ),
    .eip_o         ( eip         )
  );

  // ------------------------------------------------------------------
  // error reporting and compare tasks
  // ------------------------------------------------------------------
  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_error(input string what);
    $display("%s (at %0t ns)", what, $time);
    abort_run();
  endtask

  task automatic compare_data(input string name, input logic [DataWidth-1:0] actual,
                              input logic [DataWidth-1:0] expected);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic compare_irq(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic compare_eip(input string name, input logic [NumTargets-1:0] actual,
                             input logic [NumTargets-1:0] expected);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
      abort_run();
    end
  endtask

  // ------------------------------------------------------------------
  // bus transfers
  // ------------------------------------------------------------------
  // returns at the falling edge inside the rvalid cycle
  task automatic bus_access(input logic use_dbg, input logic we,
                            input logic [AddrWidth-1:0] addr,
                            input logic [DataWidth-1:0] wdata,
                            input logic [BeWidth-1:0] be,
                            output logic [DataWidth-1:0] rdata);
    logic granted;
    logic valid;
    @(posedge clk);
    if (use_dbg) begin
      dbg_req <= 1'b1;
      dbg_we <= we;
      dbg_addr <= addr;
      dbg_be <= be;
      dbg_wdata <= wdata;
    end else begin
      core_req <= 1'b1;
      core_we <= we;
      core_addr <= addr;
      core_be <= be;
      core_wdata <= wdata;
    end
    granted = 1'b0;
    while (!granted) begin
      @(negedge clk);
      granted = use_dbg ? dbg_gnt : core_gnt;
      @(posedge clk);
    end
    if (use_dbg) begin
      dbg_req <= 1'b0;
    end else begin
      core_req <= 1'b0;
    end
    @(negedge clk);
    valid = use_dbg ? dbg_rvalid : core_rvalid;
    if (valid !== 1'b1) begin
      report_error("no rvalid in the cycle after the grant");
    end
    rdata = use_dbg ? dbg_rdata : core_rdata;
  endtask

  task automatic bus_write(input logic use_dbg, input logic [AddrWidth-1:0] addr,
                           input logic [DataWidth-1:0] wdata, input logic [BeWidth-1:0] be);
    logic [DataWidth-1:0] rdata;
    bus_access(use_dbg, 1'b1, addr, wdata, be, rdata);
    // a write answers with zero data
    compare_data(use_dbg ? "dbg_rdata_o" : "core_rdata_o", rdata, '0);
  endtask

  task automatic bus_read(input logic use_dbg, input logic [AddrWidth-1:0] addr,
                          input logic [DataWidth-1:0] expected);
    logic [DataWidth-1:0] rdata;
    bus_access(use_dbg, 1'b0, addr, '0, '1, rdata);
    compare_data(use_dbg ? "dbg_rdata_o" : "core_rdata_o", rdata, expected);
  endtask

  // ------------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------------
  task automatic test_memory();
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] first;
    logic [DataWidth-1:0] second;
    logic [DataWidth-1:0] mask;
    logic [BeWidth-1:0] be;
    addr = {RegionMem, 24'h00_0100};
    first = {$urandom, $urandom};
    second = {$urandom, $urandom};
    be = 8'b0101_1010;
    mask = '0;
    for (int i = 0; i < BeWidth; i++) begin
      if (be[i]) begin
        mask[8*i +: 8] = 8'hFF;
      end
    end
    kept_word = (first & ~mask) | (second & mask);
    bus_write(1'b0, addr, first, '1);
    bus_write(1'b1, addr, second, be);
    bus_read(1'b0, addr, kept_word);
    // tag 0x40 is not mapped
    bus_read(1'b0, 32'h4000_0010, '0);
  endtask

  task automatic test_arbitration();
    logic [AddrWidth-1:0] dbg_a;
    logic [AddrWidth-1:0] core_a;
    logic [DataWidth-1:0] dbg_word;
    logic [DataWidth-1:0] core_word;
    dbg_a = {RegionMem, 24'h00_0200};
    core_a = {RegionMem, 24'h00_0208};
    dbg_word = {$urandom, $urandom};
    core_word = {$urandom, $urandom};
    bus_write(1'b1, dbg_a, dbg_word, '1);
    bus_write(1'b0, core_a, core_word, '1);
    @(posedge clk);
    dbg_req <= 1'b1;
    dbg_we <= 1'b0;
    dbg_addr <= dbg_a;
    dbg_be <= '1;
    core_req <= 1'b1;
    core_we <= 1'b0;
    core_addr <= core_a;
    core_be <= '1;
    @(negedge clk);
    if (dbg_gnt !== 1'b1 || core_gnt !== 1'b0) begin
      report_error("debug did not win the cycle in which both masters requested");
    end
    @(posedge clk);
    dbg_req <= 1'b0;
    @(negedge clk);
    if (core_gnt !== 1'b1) begin
      report_error("core was not granted in the cycle after debug");
    end
    if (dbg_rvalid !== 1'b1) begin
      report_error("debug got no rvalid after its grant");
    end
    compare_data("dbg_rdata_o", dbg_rdata, dbg_word);
    @(posedge clk);
    core_req <= 1'b0;
    @(negedge clk);
    if (core_rvalid !== 1'b1) begin
      report_error("core got no rvalid after its grant");
    end
    compare_data("core_rdata_o", core_rdata, core_word);
  endtask

  task automatic test_timer();
    logic [DataWidth-1:0] t1;
    logic [DataWidth-1:0] t2;
    bus_write(1'b0, {RegionClint, ClintMtimecmpOff}, '1, '1);
    compare_irq("timer_irq_o", timer_irq, 1'b0);
    bus_access(1'b0, 1'b0, {RegionClint, ClintMtimeOff}, '0, '1, t1);
    bus_access(1'b0, 1'b0, {RegionClint, ClintMtimeOff}, '0, '1, t2);
    if (!(t2 > t1)) begin
      report_error("mtime did not increase between two reads");
    end
    bus_write(1'b0, {RegionClint, ClintMtimecmpOff}, '0, '1);
    compare_irq("timer_irq_o", timer_irq, 1'b1);
    bus_write(1'b1, {RegionClint, ClintMsipOff}, 64'h1, 8'h01);
    compare_irq("ipi_o", ipi, 1'b1);
    bus_write(1'b1, {RegionClint, ClintMsipOff}, 64'h0, 8'h01);
    compare_irq("ipi_o", ipi, 1'b0);
  endtask

  task automatic test_plic();
    logic [NumSources-1:0] src;
    // target 0 takes uart (bit 1), target 1 takes gpio (bit 0)
    bus_write(1'b0, {RegionPlic, PlicEnable0Off}, 64'h2, 8'h01);
    bus_write(1'b0, {RegionPlic, PlicEnable1Off}, 64'h1, 8'h01);
    bus_read(1'b1, {RegionPlic, PlicEnable0Off}, 64'h2);
    bus_read(1'b1, {RegionPlic, PlicEnable1Off}, 64'h1);
    for (int s = 0; s < 4; s++) begin
      src = NumSources'(s);
      @(posedge clk);
      irq_sources <= src;
      @(negedge clk);
      compare_eip("eip_o", eip, {src[0], src[1]});
      bus_read(1'b0, {RegionPlic, PlicPendingOff}, {{(DataWidth-NumSources){1'b0}}, src});
    end
  endtask

  task automatic test_ndm_reset();
    bus_write(1'b0, {RegionClint, ClintMtimecmpOff}, '0, '1);
    bus_write(1'b0, {RegionClint, ClintMsipOff}, 64'h1, 8'h01);
    bus_write(1'b0, {RegionPlic, PlicEnable0Off}, 64'h3, 8'h01);
    bus_write(1'b0, {RegionPlic, PlicEnable1Off}, 64'h3, 8'h01);
    @(posedge clk);
    irq_sources <= 2'b11;
    @(negedge clk);
    compare_irq("timer_irq_o", timer_irq, 1'b1);
    compare_irq("ipi_o", ipi, 1'b1);
    compare_eip("eip_o", eip, 2'b11);
    @(posedge clk);
    ndmreset <= 1'b1;
    @(posedge clk);
    ndmreset <= 1'b0;
    repeat (NdmResetCycles + 2) @(posedge clk);
    @(negedge clk);
    compare_irq("timer_irq_o", timer_irq, 1'b0);
    compare_irq("ipi_o", ipi, 1'b0);
    compare_eip("eip_o", eip, 2'b00);
    // memory contents are outside the peripheral reset
    bus_read(1'b0, {RegionMem, 24'h00_0100}, kept_word);
  endtask

  // ------------------------------------------------------------------
  // main sequence and watchdog
  // ------------------------------------------------------------------
  initial begin
    ndmreset = 1'b0;
    core_req = 1'b0;
    core_we = 1'b0;
    core_addr = '0;
    core_be = '0;
    core_wdata = '0;
    dbg_req = 1'b0;
    dbg_we = 1'b0;
    dbg_addr = '0;
    dbg_be = '0;
    dbg_wdata = '0;
    irq_sources = '0;
    kept_word = '0;
    void'($urandom(94861));
    test_memory();
    test_arbitration();
    test_timer();
    test_plic();
    test_ndm_reset();
    if (DUT.i_xbar.i_xbar_props.fail_count != 0) begin
      report_error("an interconnect handshake assertion failed");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

  // stop at the first failed handshake assertion
  always @(negedge clk) begin
    if (DUT.i_xbar.i_xbar_props.fail_count != 0) begin
      report_error("an interconnect handshake assertion failed");
    end
  end

  // about 30 transfers of a few cycles each after reset take near 1 us
  initial begin
    #20000;
    $display("watchdog expired, a test did not finish in time");
    abort_run();
  end

endmodule

// File: verilog/soc_bus_if.sv
/*
 * soc_bus_if
 * Memory port with req/gnt/rvalid strobes. Slaves always accept, so the
 * slave side carries no grant and no response strobe.
 */
`timescale 1ns/1ps

interface soc_bus_if;
  import soc_pkg::*;

  logic req;
  logic gnt;
  logic we;
  soc_addr_u addr;
  logic [BeWidth-1:0] be;
  logic [DataWidth-1:0] wdata;
  logic rvalid;
  logic [DataWidth-1:0] rdata;

  // interconnect end of a master link
  modport master (
    input req, we, addr, be, wdata,
    output gnt, rvalid, rdata
  );

  // slave end of a slave link
  modport slave (
    input req, we, addr, be, wdata,
    output rdata
  );

  // interconnect end of a slave link
  modport xbar (
    output req, we, addr, be, wdata,
    input rdata
  );

endinterface

// File: verilog/soc_clint.sv
/*
 * soc_clint
 * Core-local interruptor: free-running mtime, mtimecmp and msip, giving
 * the timer and software interrupts of a single hart.
 */
`timescale 1ns/1ps

module soc_clint (
  input logic clk_i,
  input logic rst_i,
  soc_bus_if.slave bus,
  output logic timer_irq_o,
  output logic ipi_o
);
  import soc_pkg::*;

  logic [DataWidth-1:0] mtime_q;
  logic [DataWidth-1:0] mtimecmp_q;
  logic msip_q;
  logic [DataWidth-1:0] rdata_q;
  logic [OffWidth-1:0] offset;
  logic wr;

  assign offset = bus.addr.f.offset;
  assign wr = bus.req & bus.we;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtime_q <= '0;
      mtimecmp_q <= '1;
      msip_q <= 1'b0;
    end else begin
      // a write to mtime replaces this cycle's increment
      if (wr && offset == ClintMtimeOff) begin
        mtime_q <= byte_merge(mtime_q, bus.wdata, bus.be);
      end else begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr && offset == ClintMtimecmpOff) begin
        mtimecmp_q <= byte_merge(mtimecmp_q, bus.wdata, bus.be);
      end
      if (wr && offset == ClintMsipOff && bus.be[0]) begin
        msip_q <= bus.wdata[0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req && !bus.we) begin
      case (offset)
        ClintMsipOff: rdata_q <= {{(DataWidth-1){1'b0}}, msip_q};
        ClintMtimecmpOff: rdata_q <= mtimecmp_q;
        ClintMtimeOff: rdata_q <= mtime_q;
        default: rdata_q <= '0;
      endcase
    end
  end

  assign bus.rdata = rdata_q;
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o = msip_q;

endmodule

// File: verilog/soc_pkg.sv
/*
 * soc_pkg
 * Bus widths, address map, register offsets and the split view of a
 * bus address shared by the interconnect and its slaves.
 */
package soc_pkg;

  localparam int AddrWidth = 32;
  localparam int DataWidth = 64;
  localparam int BeWidth = DataWidth / 8;
  localparam int TagWidth = 8;
  localparam int OffWidth = AddrWidth - TagWidth;

  // region tags in the top address byte
  localparam logic [TagWidth-1:0] RegionClint = 8'h02;
  localparam logic [TagWidth-1:0] RegionPlic = 8'h0C;
  localparam logic [TagWidth-1:0] RegionMem = 8'h80;

  localparam logic [OffWidth-1:0] ClintMsipOff = 24'h00_0000;
  localparam logic [OffWidth-1:0] ClintMtimecmpOff = 24'h00_4000;
  localparam logic [OffWidth-1:0] ClintMtimeOff = 24'h00_BFF8;

  localparam logic [OffWidth-1:0] PlicPendingOff = 24'h00_1000;
  localparam logic [OffWidth-1:0] PlicEnable0Off = 24'h00_2000;
  localparam logic [OffWidth-1:0] PlicEnable1Off = 24'h00_2080;

  // source bit 0 is gpio, bit 1 is uart
  localparam int NumSources = 2;
  localparam int NumTargets = 2;

  localparam int MemWords = 512;
  localparam int MemIdxWidth = $clog2(MemWords);

  localparam int NdmResetCycles = 4;

  typedef struct packed {
    logic [TagWidth-1:0] tag;
    logic [OffWidth-1:0] offset;
  } soc_addr_fields_t;

  // one address word, seen whole or as region tag over offset
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    soc_addr_fields_t f;
  } soc_addr_u;

  function automatic logic [DataWidth-1:0] byte_merge(
    input logic [DataWidth-1:0] old_word,
    input logic [DataWidth-1:0] new_word,
    input logic [BeWidth-1:0] be
  );
    logic [DataWidth-1:0] merged;
    merged = old_word;
    for (int i = 0; i < BeWidth; i++) begin
      if (be[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

endpackage

// File: verilog/soc_plic.sv
/*
 * soc_plic
 * Reduced platform interrupt controller. Each target line is the OR of
 * its enabled level sources, no priorities and no claim.
 */
`timescale 1ns/1ps

module soc_plic (
  input logic clk_i,
  input logic rst_i,
  soc_bus_if.slave bus,
  input logic [soc_pkg::NumSources-1:0] irq_sources_i,
  output logic [soc_pkg::NumTargets-1:0] eip_o
);
  import soc_pkg::*;

  localparam logic [OffWidth-1:0] EnableStride = PlicEnable1Off - PlicEnable0Off;

  logic [NumSources-1:0] enable_q [NumTargets];
  logic [DataWidth-1:0] rdata_d;
  logic [DataWidth-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int t = 0; t < NumTargets; t++) begin
        enable_q[t] <= '0;
      end
    end else if (bus.req && bus.we && bus.be[0]) begin
      for (int t = 0; t < NumTargets; t++) begin
        if (bus.addr.f.offset == PlicEnable0Off + OffWidth'(t) * EnableStride) begin
          enable_q[t] <= bus.wdata[NumSources-1:0];
        end
      end
    end
  end

  // pending is simply the live source level
  always_comb begin
    rdata_d = '0;
    if (bus.addr.f.offset == PlicPendingOff) begin
      rdata_d[NumSources-1:0] = irq_sources_i;
    end
    for (int t = 0; t < NumTargets; t++) begin
      if (bus.addr.f.offset == PlicEnable0Off + OffWidth'(t) * EnableStride) begin
        rdata_d[NumSources-1:0] = enable_q[t];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req && !bus.we) begin
      rdata_q <= rdata_d;
    end
  end

  assign bus.rdata = rdata_q;

  for (genvar t = 0; t < NumTargets; t++) begin : g_target
    assign eip_o[t] = |(enable_q[t] & irq_sources_i);
  end

endmodule

// File: verilog/soc_reset_gen.sv
/*
 * soc_reset_gen
 * Peripheral reset from power-on and debug non-debug reset, held for a
 * few cycles after both causes drop.
 */
`timescale 1ns/1ps

module soc_reset_gen (
  input logic clk_i,
  input logic rst_i,
  input logic ndmreset_i,
  output logic periph_rst_o
);
  import soc_pkg::*;

  localparam int CntWidth = $clog2(NdmResetCycles + 1);

  logic [CntWidth-1:0] cnt_q;

  always_ff @(posedge clk_i) begin
    if (rst_i || ndmreset_i) begin
      cnt_q <= CntWidth'(NdmResetCycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign periph_rst_o = rst_i | ndmreset_i | (cnt_q != '0);

endmodule

// File: verilog/soc_scratch_mem.sv
/*
 * soc_scratch_mem
 * Byte-enabled word memory in place of DRAM, registered read port.
 */
`timescale 1ns/1ps

module soc_scratch_mem (
  input logic clk_i,
  soc_bus_if.slave bus
);
  import soc_pkg::*;

  logic [DataWidth-1:0] mem_q [MemWords];
  logic [DataWidth-1:0] rdata_q;
  logic [MemIdxWidth-1:0] idx;

  // drop the byte offset within a word
  assign idx = bus.addr.f.offset[MemIdxWidth+2:3];

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        mem_q[idx] <= byte_merge(mem_q[idx], bus.wdata, bus.be);
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  assign bus.rdata = rdata_q;

endmodule

// File: verilog/soc_top.sv
/*
 * soc_top
 * Memory-mapped core of the SoC: core and debug master ports, the
 * interconnect, CLINT, PLIC, scratch memory and reset generation.
 */
`timescale 1ns/1ps

module soc_top (
  input logic clk_i,
  input logic rst_i,
  input logic ndmreset_i,
  // core master port
  input logic core_req_i,
  output logic core_gnt_o,
  input logic core_we_i,
  input logic [soc_pkg::AddrWidth-1:0] core_addr_i,
  input logic [soc_pkg::BeWidth-1:0] core_be_i,
  input logic [soc_pkg::DataWidth-1:0] core_wdata_i,
  output logic core_rvalid_o,
  output logic [soc_pkg::DataWidth-1:0] core_rdata_o,
  // debug master port
  input logic dbg_req_i,
  output logic dbg_gnt_o,
  input logic dbg_we_i,
  input logic [soc_pkg::AddrWidth-1:0] dbg_addr_i,
  input logic [soc_pkg::BeWidth-1:0] dbg_be_i,
  input logic [soc_pkg::DataWidth-1:0] dbg_wdata_i,
  output logic dbg_rvalid_o,
  output logic [soc_pkg::DataWidth-1:0] dbg_rdata_o,
  // interrupts
  input logic [soc_pkg::NumSources-1:0] irq_sources_i,
  output logic timer_irq_o,
  output logic ipi_o,
  output logic [soc_pkg::NumTargets-1:0] eip_o
);

  logic periph_rst;

  soc_bus_if core_bus ();
  soc_bus_if dbg_bus ();
  soc_bus_if clint_bus ();
  soc_bus_if plic_bus ();
  soc_bus_if mem_bus ();

  assign core_bus.req = core_req_i;
  assign core_bus.we = core_we_i;
  assign core_bus.addr.raw = core_addr_i;
  assign core_bus.be = core_be_i;
  assign core_bus.wdata = core_wdata_i;
  assign core_gnt_o = core_bus.gnt;
  assign core_rvalid_o = core_bus.rvalid;
  assign core_rdata_o = core_bus.rdata;

  assign dbg_bus.req = dbg_req_i;
  assign dbg_bus.we = dbg_we_i;
  assign dbg_bus.addr.raw = dbg_addr_i;
  assign dbg_bus.be = dbg_be_i;
  assign dbg_bus.wdata = dbg_wdata_i;
  assign dbg_gnt_o = dbg_bus.gnt;
  assign dbg_rvalid_o = dbg_bus.rvalid;
  assign dbg_rdata_o = dbg_bus.rdata;

  soc_reset_gen i_reset_gen (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .ndmreset_i   ( ndmreset_i ),
    .periph_rst_o ( periph_rst )
  );

  soc_xbar i_xbar (
    .clk_i ( clk_i      ),
    .rst_i ( periph_rst ),
    .dbg   ( dbg_bus    ),
    .core  ( core_bus   ),
    .clint ( clint_bus  ),
    .plic  ( plic_bus   ),
    .mem   ( mem_bus    )
  );

  soc_clint i_clint (
    .clk_i       ( clk_i       ),
    .rst_i       ( periph_rst  ),
    .bus         ( clint_bus   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  soc_plic i_plic (
    .clk_i         ( clk_i         ),
    .rst_i         ( periph_rst    ),
    .bus           ( plic_bus      ),
    .irq_sources_i ( irq_sources_i ),
    .eip_o         ( eip_o         )
  );

  // contents survive a non-debug reset
  soc_scratch_mem i_scratch_mem (
    .clk_i ( clk_i   ),
    .bus   ( mem_bus )
  );

endmodule

// File: verilog/soc_xbar.sv
/*
 * soc_xbar
 * Two-master interconnect. Debug wins over core, one grant per cycle.
 * The region tag selects the slave, the response comes back one cycle
 * after the grant.
 */
`timescale 1ns/1ps

module soc_xbar (
  input logic clk_i,
  input logic rst_i,
  soc_bus_if.master dbg,
  soc_bus_if.master core,
  soc_bus_if.xbar clint,
  soc_bus_if.xbar plic,
  soc_bus_if.xbar mem
);
  import soc_pkg::*;

  logic dbg_win;
  logic fwd_req;
  logic fwd_we;
  soc_addr_u fwd_addr;
  logic [BeWidth-1:0] fwd_be;
  logic [DataWidth-1:0] fwd_wdata;
  logic hit_clint;
  logic hit_plic;
  logic hit_mem;

  logic rsp_valid_q;
  logic rsp_dbg_q;
  // one-hot {mem, plic, clint}, set only for mapped reads
  logic [2:0] rsp_sel_q;
  logic [DataWidth-1:0] rsp_data;

  // ----------------------------------------------------------------------
  // arbitration and request forwarding
  // ----------------------------------------------------------------------
  assign dbg_win = dbg.req;
  assign fwd_req = (dbg.req | core.req) & ~rst_i;

  assign dbg.gnt = dbg.req & ~rst_i;
  assign core.gnt = core.req & ~dbg.req & ~rst_i;

  assign fwd_we = dbg_win ? dbg.we : core.we;
  assign fwd_addr = dbg_win ? dbg.addr : core.addr;
  assign fwd_be = dbg_win ? dbg.be : core.be;
  assign fwd_wdata = dbg_win ? dbg.wdata : core.wdata;

  assign hit_clint = (fwd_addr.f.tag == RegionClint);
  assign hit_plic = (fwd_addr.f.tag == RegionPlic);
  assign hit_mem = (fwd_addr.f.tag == RegionMem);

  // unmapped tags reach no slave
  assign clint.req = fwd_req & hit_clint;
  assign clint.we = fwd_we;
  assign clint.addr = fwd_addr;
  assign clint.be = fwd_be;
  assign clint.wdata = fwd_wdata;

  assign plic.req = fwd_req & hit_plic;
  assign plic.we = fwd_we;
  assign plic.addr = fwd_addr;
  assign plic.be = fwd_be;
  assign plic.wdata = fwd_wdata;

  assign mem.req = fwd_req & hit_mem;
  assign mem.we = fwd_we;
  assign mem.addr = fwd_addr;
  assign mem.be = fwd_be;
  assign mem.wdata = fwd_wdata;

  // ----------------------------------------------------------------------
  // response routing
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
      rsp_dbg_q <= 1'b0;
      rsp_sel_q <= '0;
    end else begin
      rsp_valid_q <= fwd_req;
      rsp_dbg_q <= fwd_req & dbg_win;
      rsp_sel_q <= (fwd_req & ~fwd_we) ? {hit_mem, hit_plic, hit_clint} : 3'b000;
    end
  end

  // writes and unmapped reads return zero
  assign rsp_data = ({DataWidth{rsp_sel_q[0]}} & clint.rdata) |
                    ({DataWidth{rsp_sel_q[1]}} & plic.rdata) |
                    ({DataWidth{rsp_sel_q[2]}} & mem.rdata);

  assign dbg.rvalid = rsp_valid_q & rsp_dbg_q;
  assign core.rvalid = rsp_valid_q & ~rsp_dbg_q;
  assign dbg.rdata = rsp_dbg_q ? rsp_data : '0;
  assign core.rdata = rsp_dbg_q ? '0 : rsp_data;

endmodule
